// File: verilog/ws_ctrl_pkg.sv
`default_nettype none

package ws_ctrl_pkg;

  // SRAM address width, shared by activation/weight and psum ports
  localparam int ADDR_W = 11;

  // PE columns, also the weight words loaded per pass
  localparam int COLS = 8;

  // Width of the num_nij / num_kij configuration counts
  localparam int CFG_W = 8;

  // In-phase step counter must reach num_nij + COMPUTE_TAIL
  localparam int STEP_W = CFG_W + $clog2(COLS);

  // Phase lengths in cycles
  localparam int WEIGHT_LOAD_CYCLES = COLS;
  localparam int ARRAY_LOAD_CYCLES  = 3 * COLS;

  // Compute runs num_nij + COMPUTE_TAIL cycles to flush the array
  localparam int COMPUTE_TAIL = 2 * COLS + 3;

  // Controller phases
  typedef enum logic [2:0] {
    PH_IDLE       = 3'd0,
    PH_WEIGHT_L0  = 3'd1,
    PH_ARRAY_LOAD = 3'd2,
    PH_ACT_L0     = 3'd3,
    PH_COMPUTE    = 3'd4,
    PH_SFU_START  = 3'd5,
    PH_SFU_WAIT   = 3'd6
  } phase_t;

endpackage

`default_nettype wire

// File: verilog/phase_sequencer.sv
`default_nettype none

module phase_sequencer
  import ws_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic [CFG_W-1:0]  num_nij,
  input  logic [CFG_W-1:0]  num_kij,
  input  logic              sfu_active,
  output phase_t            phase,
  output logic [STEP_W-1:0] step,
  output logic [CFG_W-1:0]  pass,
  output phase_t            next_phase,
  output logic [STEP_W-1:0] next_step,
  output logic              controller_active
);

  logic [STEP_W-1:0] nij_ext;
  logic [STEP_W-1:0] last_step;
  logic              phase_done;
  logic              last_pass;

  assign nij_ext = STEP_W'(num_nij);

  // Final step index of the current phase
  always_comb begin
    case (phase)
      PH_WEIGHT_L0:  last_step = STEP_W'(WEIGHT_LOAD_CYCLES - 1);
      PH_ARRAY_LOAD: last_step = STEP_W'(ARRAY_LOAD_CYCLES - 1);
      PH_ACT_L0:     last_step = nij_ext - 1'b1;
      PH_COMPUTE:    last_step = nij_ext + STEP_W'(COMPUTE_TAIL - 1);
      default:       last_step = '0;
    endcase
  end

  assign phase_done = (step == last_step);
  assign last_pass  = (pass == num_kij - 1'b1);

  // Next phase
  always_comb begin
    next_phase = phase;
    case (phase)
      PH_IDLE: begin
        if (start) begin
          next_phase = PH_WEIGHT_L0;
        end
      end
      PH_WEIGHT_L0: begin
        if (phase_done) begin
          next_phase = PH_ARRAY_LOAD;
        end
      end
      PH_ARRAY_LOAD: begin
        if (phase_done) begin
          next_phase = PH_ACT_L0;
        end
      end
      PH_ACT_L0: begin
        if (phase_done) begin
          next_phase = PH_COMPUTE;
        end
      end
      PH_COMPUTE: begin
        // Loop back for another kernel pass or hand off to the SFU
        if (phase_done) begin
          next_phase = last_pass ? PH_SFU_START : PH_WEIGHT_L0;
        end
      end
      PH_SFU_START: begin
        next_phase = PH_SFU_WAIT;
      end
      PH_SFU_WAIT: begin
        if (!sfu_active) begin
          next_phase = PH_IDLE;
        end
      end
      default: begin
        next_phase = PH_IDLE;
      end
    endcase
  end

  // Step restarts at 0 on every phase entry, held at 0 in idle
  always_comb begin
    if (next_phase != phase || phase == PH_IDLE) begin
      next_step = '0;
    end else begin
      next_step = step + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      phase             <= PH_IDLE;
      step              <= '0;
      controller_active <= 1'b0;
    end else begin
      phase             <= next_phase;
      step              <= next_step;
      controller_active <= (next_phase != PH_IDLE);
    end
  end

  // Pass counter, bumped as each compute phase ends
  always_ff @(posedge clk) begin
    if (reset) begin
      pass <= '0;
    end else if (phase == PH_IDLE) begin
      pass <= '0;
    end else if (phase == PH_COMPUTE && phase_done) begin
      pass <= pass + 1'b1;
    end
  end

  a_phase_legal: assert property (
    @(posedge clk) disable iff (reset)
    phase inside {PH_IDLE, PH_WEIGHT_L0, PH_ARRAY_LOAD, PH_ACT_L0,
                  PH_COMPUTE, PH_SFU_START, PH_SFU_WAIT}
  ) else $error("phase register left the legal encodings");

endmodule

`default_nettype wire

// File: verilog/array_strobe_gen.sv
`default_nettype none

module array_strobe_gen
  import ws_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  phase_t            next_phase,
  input  logic [STEP_W-1:0] next_step,
  input  logic [CFG_W-1:0]  num_nij,
  output logic              l0_wr,
  output logic              l0_rd,
  output logic              load,
  output logic              execute,
  output logic              mac_reset,
  output logic              sfu_start
);

  logic load_d;
  logic execute_d;
  logic l0_wr_d;
  logic mac_reset_d;

  // Decoded from the upcoming phase so the registered strobes line up
  // with the phase cycles themselves

  // Weight and activation fills both write L0
  assign l0_wr_d = (next_phase == PH_WEIGHT_L0) || (next_phase == PH_ACT_L0);

  // Only the first COLS array-load cycles shift weights in
  assign load_d = (next_phase == PH_ARRAY_LOAD) && (next_step < STEP_W'(COLS));

  // One execute per activation vector
  assign execute_d = (next_phase == PH_COMPUTE) && (next_step < STEP_W'(num_nij));

  // Clear the accumulators early in each weight load
  assign mac_reset_d = (next_phase == PH_WEIGHT_L0) && (next_step == STEP_W'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      l0_wr     <= 1'b0;
      l0_rd     <= 1'b0;
      load      <= 1'b0;
      execute   <= 1'b0;
      mac_reset <= 1'b0;
      sfu_start <= 1'b0;
    end else begin
      l0_wr     <= l0_wr_d;
      l0_rd     <= load_d || execute_d;
      load      <= load_d;
      execute   <= execute_d;
      mac_reset <= mac_reset_d;
      sfu_start <= (next_phase == PH_SFU_START);
    end
  end

  a_l0_exclusive: assert property (
    @(posedge clk) disable iff (reset)
    !(l0_wr && l0_rd)
  ) else $error("L0 read and write asserted in the same cycle");

endmodule

`default_nettype wire

// File: verilog/sram_addr_gen.sv
`default_nettype none

module sram_addr_gen
  import ws_ctrl_pkg::*;
(
  input  phase_t            phase,
  input  logic [STEP_W-1:0] step,
  input  logic [CFG_W-1:0]  pass,
  input  logic [CFG_W-1:0]  num_nij,
  input  logic [ADDR_W-1:0] weight_base,
  input  logic [ADDR_W-1:0] act_base,
  input  logic [STEP_W-1:0] drained,
  output logic [ADDR_W-1:0] act_sram_addr,
  output logic [ADDR_W-1:0] psum_sram_addr
);

  logic [ADDR_W-1:0] weight_offset;
  logic [ADDR_W-1:0] psum_offset;

  // Each pass reads the next column group of weights
  assign weight_offset = ADDR_W'(pass) * ADDR_W'(COLS);

  // Each pass writes its own block of num_nij partial sums
  assign psum_offset = ADDR_W'(pass) * ADDR_W'(num_nij);

  // Weights and activations share one SRAM port
  always_comb begin
    case (phase)
      PH_WEIGHT_L0: begin
        act_sram_addr = weight_base + weight_offset + ADDR_W'(step);
      end
      PH_ACT_L0: begin
        act_sram_addr = act_base + ADDR_W'(step);
      end
      default: begin
        act_sram_addr = '0;
      end
    endcase
  end

  // Psum address advances with each completed OFIFO read
  always_comb begin
    if (phase == PH_COMPUTE) begin
      psum_sram_addr = psum_offset + ADDR_W'(drained);
    end else begin
      psum_sram_addr = '0;
    end
  end

endmodule

`default_nettype wire

// File: verilog/psum_drain.sv
`default_nettype none

module psum_drain
  import ws_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  phase_t            phase,
  input  logic [STEP_W-1:0] step,
  input  logic [CFG_W-1:0]  num_nij,
  input  logic              ofifo_valid,
  output logic              ofifo_rd,
  output logic [STEP_W-1:0] drained
);

  logic [STEP_W-1:0] rd_limit;
  logic              rd_window;

  // Reads stop two cycles before compute ends so none spill past it
  assign rd_limit  = STEP_W'(num_nij) + STEP_W'(2 * COLS + 1);
  assign rd_window = (phase == PH_COMPUTE) && (step < rd_limit);

  // Read strobe one cycle behind valid
  always_ff @(posedge clk) begin
    if (reset) begin
      ofifo_rd <= 1'b0;
    end else begin
      ofifo_rd <= rd_window && ofifo_valid;
    end
  end

  // Completed reads in this compute phase
  always_ff @(posedge clk) begin
    if (reset) begin
      drained <= '0;
    end else if (phase != PH_COMPUTE) begin
      drained <= '0;
    end else if (ofifo_rd) begin
      drained <= drained + 1'b1;
    end
  end

  a_rd_in_compute: assert property (
    @(posedge clk) disable iff (reset)
    ofifo_rd |-> (phase == PH_COMPUTE)
  ) else $error("OFIFO read outside the compute phase");

endmodule

`default_nettype wire

// File: verilog/ws_controller.sv
`default_nettype none

module ws_controller
  import ws_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  logic [CFG_W-1:0]  num_nij,
  input  logic [CFG_W-1:0]  num_kij,
  input  logic [ADDR_W-1:0] weight_base,
  input  logic [ADDR_W-1:0] act_base,
  input  logic              ofifo_valid,
  input  logic              sfu_active,
  output logic              load,
  output logic              execute,
  output logic              mac_reset,
  output logic              l0_rd,
  output logic              l0_wr,
  output logic              ofifo_rd,
  output logic              sfu_start,
  output logic              sfu_busy,
  output logic              controller_active,
  output logic [ADDR_W-1:0] act_sram_addr,
  output logic [ADDR_W-1:0] psum_sram_addr
);

  phase_t            phase;
  phase_t            next_phase;
  logic [STEP_W-1:0] step;
  logic [STEP_W-1:0] next_step;
  logic [CFG_W-1:0]  pass;
  logic [STEP_W-1:0] drained;

  phase_sequencer u_seq (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .num_nij           (num_nij),
    .num_kij           (num_kij),
    .sfu_active        (sfu_active),
    .phase             (phase),
    .step              (step),
    .pass              (pass),
    .next_phase        (next_phase),
    .next_step         (next_step),
    .controller_active (controller_active)
  );

  array_strobe_gen u_strobe (
    .clk        (clk),
    .reset      (reset),
    .next_phase (next_phase),
    .next_step  (next_step),
    .num_nij    (num_nij),
    .l0_wr      (l0_wr),
    .l0_rd      (l0_rd),
    .load       (load),
    .execute    (execute),
    .mac_reset  (mac_reset),
    .sfu_start  (sfu_start)
  );

  sram_addr_gen u_addr (
    .phase          (phase),
    .step           (step),
    .pass           (pass),
    .num_nij        (num_nij),
    .weight_base    (weight_base),
    .act_base       (act_base),
    .drained        (drained),
    .act_sram_addr  (act_sram_addr),
    .psum_sram_addr (psum_sram_addr)
  );

  psum_drain u_drain (
    .clk         (clk),
    .reset       (reset),
    .phase       (phase),
    .step        (step),
    .num_nij     (num_nij),
    .ofifo_valid (ofifo_valid),
    .ofifo_rd    (ofifo_rd),
    .drained     (drained)
  );

  // Covers the gap between sfu_start and the SFU raising sfu_active
  assign sfu_busy = sfu_active || (phase == PH_SFU_WAIT);

endmodule

`default_nettype wire

// File: bench/ws_tb_tasks.svh
`ifndef WS_TB_TASKS_SVH
`define WS_TB_TASKS_SVH

task automatic check_equal(input string what, input int expected, input int actual);
  if (expected != actual) begin
    abort_run($sformatf("ERROR %s %s: expected %0d, actual %0d",
                        test_name, what, expected, actual));
  end
endtask

task automatic clear_monitor();
  monitor_clear = 1'b1;
  @(negedge clk);
  monitor_clear = 1'b0;
endtask

// Returns in the cycle after start was sampled
task automatic start_run(input int nij, input int kij, input int wbase, input int abase);
  @(negedge clk);
  num_nij     = CFG_W'(nij);
  num_kij     = CFG_W'(kij);
  weight_base = ADDR_W'(wbase);
  act_base    = ADDR_W'(abase);
  start       = 1'b1;
  @(negedge clk);
  start = 1'b0;
endtask

task automatic wait_run_done();
  while (controller_active) begin
    @(negedge clk);
  end
endtask

// Length of one full pass from weight load through compute
function automatic int pass_cycles(input int nij);
  return COLS + 3 * COLS + nij + (nij + 2 * COLS + 3);
endfunction

task automatic test_reset_and_start();
  test_name = "reset_and_start";
  @(negedge clk);
  check_equal("outputs after reset", 0,
              int'({load, execute, mac_reset, l0_rd, l0_wr, ofifo_rd,
                    sfu_start, sfu_busy, controller_active}));
  check_equal("act_sram_addr after reset", 0, int'(act_sram_addr));
  check_equal("psum_sram_addr after reset", 0, int'(psum_sram_addr));
  start_run(2, 1, 0, 0);
  check_equal("controller_active after start", 1, int'(controller_active));
  wait_run_done();
endtask

task automatic test_single_pass();
  int nij = 5;
  int wbase = 'h040;
  int abase = 'h200;
  test_name = "single_pass";
  clear_monitor();
  start_run(nij, 1, wbase, abase);
  wait_run_done();
  check_equal("l0_wr cycles", COLS + nij, l0_wr_cycles);
  check_equal("l0_rd cycles", COLS + nij, l0_rd_cycles);
  check_equal("load cycles", COLS, load_cycles);
  check_equal("execute cycles", nij, execute_cycles);
  check_equal("mac_reset pulses", 1, mac_reset_count);
  check_equal("run length", pass_cycles(nij) + 2, active_cycles);
  check_equal("address count", COLS + nij, addr_log.size());
  for (int i = 0; i < COLS; i++) begin
    check_equal("weight address", wbase + i, addr_log[i]);
  end
  for (int i = 0; i < nij; i++) begin
    check_equal("activation address", abase + i, addr_log[COLS + i]);
  end
endtask

task automatic test_three_passes();
  int nij = 4;
  int kij = 3;
  int wbase = 'h100;
  int abase = 'h300;
  test_name = "three_passes";
  clear_monitor();
  start_run(nij, kij, wbase, abase);
  wait_run_done();
  check_equal("mac_reset pulses", kij, mac_reset_count);
  check_equal("sfu_start pulses", 1, sfu_start_count);
  check_equal("run length", kij * pass_cycles(nij) + 2, active_cycles);
  check_equal("L0 fills", 2 * kij, fill_starts.size());
  // Weight fill then activation fill in every pass
  for (int p = 0; p < kij; p++) begin
    check_equal("weight start address", wbase + p * COLS, fill_starts[2 * p]);
    check_equal("activation start address", abase, fill_starts[2 * p + 1]);
  end
endtask

task automatic test_ofifo_drain();
  int nij = 6;
  int kij = 2;
  test_name = "ofifo_drain";
  clear_monitor();
  random_valid_en = 1'b1;
  start_run(nij, kij, 'h010, 'h080);
  wait_run_done();
  random_valid_en = 1'b0;
  check_equal("reads without valid", 0, rd_without_valid);
  check_equal("any reads seen", 1, int'(rd_count > 0));
  check_equal("last drained pass", kij - 1, psum_pass_log[psum_pass_log.size() - 1]);
  for (int i = 0; i < psum_addr_log.size(); i++) begin
    check_equal("psum address", psum_pass_log[i] * nij + psum_idx_log[i], psum_addr_log[i]);
  end
endtask

task automatic test_sfu_handshake();
  int nij = 3;
  test_name = "sfu_handshake";
  clear_monitor();
  start_run(nij, 1, 'h020, 'h0a0);
  repeat (6) @(negedge clk);
  // Extra start while busy
  start = 1'b1;
  @(negedge clk);
  start = 1'b0;
  while (!sfu_start) begin
    @(negedge clk);
  end
  sfu_active = 1'b1;
  for (int i = 0; i < 10; i++) begin
    @(negedge clk);
    check_equal("sfu_busy while sfu active", 1, int'(sfu_busy));
    check_equal("controller_active while sfu active", 1, int'(controller_active));
  end
  sfu_active = 1'b0;
  @(negedge clk);
  check_equal("sfu_busy after release", 0, int'(sfu_busy));
  check_equal("controller_active after release", 0, int'(controller_active));
  repeat (COLS) @(negedge clk);
  check_equal("controller_active after mid-run start", 0, int'(controller_active));
  check_equal("mac_reset pulses", 1, mac_reset_count);
  check_equal("sfu_start pulses", 1, sfu_start_count);
endtask

`endif

// File: bench/ws_controller_tb.sv
`default_nettype none

module ws_controller_tb
  import ws_ctrl_pkg::*;
();

  // Eight passes in all, each 6*COLS+3 fixed cycles plus twice its num_nij
  // (34 summed over the runs), two SFU cycles per run and the 10-cycle SFU hold
  localparam int RUN_CYCLES     = 8 * (6 * COLS + 3) + 2 * 34 + 5 * 2 + 10;
  localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;

  logic              clk = 1'b0;
  logic              reset;
  logic              start;
  logic [CFG_W-1:0]  num_nij;
  logic [CFG_W-1:0]  num_kij;
  logic [ADDR_W-1:0] weight_base;
  logic [ADDR_W-1:0] act_base;
  logic              ofifo_valid = 1'b0;
  logic              sfu_active;
  logic              load;
  logic              execute;
  logic              mac_reset;
  logic              l0_rd;
  logic              l0_wr;
  logic              ofifo_rd;
  logic              sfu_start;
  logic              sfu_busy;
  logic              controller_active;
  logic [ADDR_W-1:0] act_sram_addr;
  logic [ADDR_W-1:0] psum_sram_addr;

  // Monitor state, cleared between tests
  logic monitor_clear;
  logic l0_wr_prev = 1'b0;
  logic valid_prev = 1'b0;
  int   active_cycles;
  int   l0_wr_cycles;
  int   l0_rd_cycles;
  int   load_cycles;
  int   execute_cycles;
  int   mac_reset_count;
  int   sfu_start_count;
  int   rd_count;
  int   rd_without_valid;
  int   reads_in_pass;
  int   addr_log[$];
  int   fill_starts[$];
  int   psum_addr_log[$];
  int   psum_pass_log[$];
  int   psum_idx_log[$];

  string  test_name;
  integer seed = 73402;
  logic   random_valid_en = 1'b0;
  logic   valid_draw;
  int     cycle_count = 0;

  ws_controller u_dut (
    .clk               (clk),
    .reset             (reset),
    .start             (start),
    .num_nij           (num_nij),
    .num_kij           (num_kij),
    .weight_base       (weight_base),
    .act_base          (act_base),
    .ofifo_valid       (ofifo_valid),
    .sfu_active        (sfu_active),
    .load              (load),
    .execute           (execute),
    .mac_reset         (mac_reset),
    .l0_rd             (l0_rd),
    .l0_wr             (l0_wr),
    .ofifo_rd          (ofifo_rd),
    .sfu_start         (sfu_start),
    .sfu_busy          (sfu_busy),
    .controller_active (controller_active),
    .act_sram_addr     (act_sram_addr),
    .psum_sram_addr    (psum_sram_addr)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "Stopping at first failure");
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: run exceeded %0d cycles in test %s",
                          TIMEOUT_CYCLES, test_name));
    end
  end

  // Random OFIFO valid, one draw on every falling edge, gated by the enable
  always @(negedge clk) begin
    valid_draw  = 1'($random(seed));
    ofifo_valid = random_valid_en & valid_draw;
  end

  // Samples the cycle that just ended
  always @(posedge clk) begin
    if (reset || monitor_clear) begin
      active_cycles    = 0;
      l0_wr_cycles     = 0;
      l0_rd_cycles     = 0;
      load_cycles      = 0;
      execute_cycles   = 0;
      mac_reset_count  = 0;
      sfu_start_count  = 0;
      rd_count         = 0;
      rd_without_valid = 0;
      reads_in_pass    = 0;
      l0_wr_prev       = 1'b0;
      valid_prev       = 1'b0;
      addr_log.delete();
      fill_starts.delete();
      psum_addr_log.delete();
      psum_pass_log.delete();
      psum_idx_log.delete();
    end else begin
      if (controller_active) begin
        active_cycles++;
      end
      if (l0_wr) begin
        l0_wr_cycles++;
        addr_log.push_back(int'(act_sram_addr));
        // First address of each L0 fill
        if (!l0_wr_prev) begin
          fill_starts.push_back(int'(act_sram_addr));
        end
      end
      if (l0_rd) begin
        l0_rd_cycles++;
      end
      if (load) begin
        load_cycles++;
      end
      if (execute) begin
        execute_cycles++;
      end
      if (mac_reset) begin
        mac_reset_count++;
        reads_in_pass = 0;
      end
      if (sfu_start) begin
        sfu_start_count++;
      end
      if (ofifo_rd) begin
        rd_count++;
        if (!valid_prev) begin
          rd_without_valid++;
        end
        psum_addr_log.push_back(int'(psum_sram_addr));
        psum_pass_log.push_back(mac_reset_count - 1);
        psum_idx_log.push_back(reads_in_pass);
        reads_in_pass++;
      end
      l0_wr_prev = l0_wr;
      valid_prev = ofifo_valid;
    end
  end

  `include "ws_tb_tasks.svh"

  initial begin
    reset         = 1'b1;
    start         = 1'b0;
    num_nij       = '0;
    num_kij       = '0;
    weight_base   = '0;
    act_base      = '0;
    sfu_active    = 1'b0;
    monitor_clear = 1'b0;
    test_name     = "reset";
    repeat (5) @(negedge clk);
    reset = 1'b0;
    test_reset_and_start();
    test_single_pass();
    test_three_passes();
    test_ofifo_drain();
    test_sfu_handshake();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+bench
verilog/ws_ctrl_pkg.sv
verilog/phase_sequencer.sv
verilog/array_strobe_gen.sv
verilog/sram_addr_gen.sv
verilog/psum_drain.sv
verilog/ws_controller.sv
bench/ws_controller_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= ws_controller_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
